// File: Makefile
VERILATOR = verilator
FLAGS     = --timing
TOP       = tb_ifm_buffer
FLIST     = flist.f
OBJ_DIR   = obj_dir
PASS_MSG  = PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) -f $(FLIST) --top-module $(TOP)

# pass only if the simulation prints the pass line
sim:
	$(VERILATOR) --binary $(FLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: flist.f
+incdir+hdl
+incdir+tests
hdl/ifm_buffer_pkg.sv
hdl/ifm_buffer_if.sv
hdl/ifm_pad_ctrl.sv
hdl/ifm_pad_datapath.sv
hdl/ifm_lane_fifo.sv
hdl/ifm_buffer_top.sv
tests/tb_ifm_buffer.sv

// File: hdl/ifm_buffer_if.sv
/* pad_ctrl_if links the padding controller to the datapath,
   bank_ctrl_if fans the bank strobes out to every lane FIFO */
`timescale 1ns/100ps

interface pad_ctrl_if;

    ifm_buffer_pkg::lane_cnt_t lane_count;
    ifm_buffer_pkg::pad_mode_e pad_mode;
    ifm_buffer_pkg::phase_t    phase;      // for waves
    logic                      pad_active; // for waves

    modport ctrl (
        output lane_count,
        output pad_mode,
        output phase,
        output pad_active
    );

    modport dp (
        input lane_count,
        input pad_mode,
        input phase,
        input pad_active
    );

endinterface

interface bank_ctrl_if;

    logic rd_clr_1;
    logic wr_clr_1;
    logic wr_en_1;
    logic rd_clr_2;
    logic wr_clr_2;
    logic wr_en_2;
    logic wr_bank;  // 0 fills bank 1, 1 fills bank 2
    logic rd_bank;  // selects the output register

    modport src (
        output rd_clr_1, wr_clr_1, wr_en_1,
        output rd_clr_2, wr_clr_2, wr_en_2,
        output wr_bank, rd_bank
    );

    modport lane (
        input rd_clr_1, wr_clr_1, wr_en_1,
        input rd_clr_2, wr_clr_2, wr_en_2,
        input wr_bank, rd_bank
    );

endinterface

// File: hdl/ifm_buffer_pkg.sv
/* shared types of the ifm buffer, sized from the settings header */
`include "ifm_buffer_settings.svh"

package ifm_buffer_pkg;

    typedef logic [`IFM_DATA_WIDTH-1:0] lane_word_t;

    // lane 0 sits in the low bits
    typedef lane_word_t [`IFM_NUM_LANES-1:0] lane_bus_t;

    typedef logic [`IFM_NUM_LANES-1:0] lane_mask_t;

    // 0 to 16 lanes, so one bit more than the lane index
    typedef logic [$clog2(`IFM_NUM_LANES + 1)-1:0] lane_cnt_t;

    typedef logic [`IFM_TILE_WIDTH-1:0] tile_idx_t;

    typedef logic [`IFM_MAP_WIDTH-1:0] map_size_t;

    typedef logic [`IFM_PHASE_WIDTH-1:0] phase_t;

    // what the datapath does to the masked bus
    typedef enum logic [1:0] {
        PAD_PASS,   // masked bus unchanged
        PAD_ZERO,   // whole bus zero on a top or bottom row
        PAD_SHIFT,  // left border
        PAD_TRIM    // right border
    } pad_mode_e;

endpackage

// File: hdl/ifm_buffer_settings.svh
/* sizes and padding conditions of the ifm buffer
   depth is per bank, there is no full or empty flag, the user must not overrun it */
`ifndef IFM_BUFFER_SETTINGS_SVH
`define IFM_BUFFER_SETTINGS_SVH

// lane datapath
`define IFM_DATA_WIDTH      16
`define IFM_NUM_LANES       16

// words per bank
`define IFM_FIFO_DEPTH      64

// control field widths
`define IFM_TILE_WIDTH      14
`define IFM_MAP_WIDTH       9
`define IFM_PHASE_WIDTH     4
`define IFM_LAYER_WIDTH     4
`define IFM_KERNEL_WIDTH    2

// 3x3 window, phases 0..8
`define IFM_PHASE_LAST      4'd8

// padding only for 3x3 kernels from layer 2 on
`define IFM_PAD_KERNEL      2'd3
`define IFM_PAD_FIRST_LAYER 4'd2

`endif

// File: hdl/ifm_buffer_top.sv
/* lane mask and border padding in front of 16 double-banked lane FIFOs
   writes, reads and clears are plain strobes without back-pressure
   data_out lane k is valid the cycle after rd_en of that lane and bank */
`timescale 1ns/100ps
`include "ifm_buffer_settings.svh"

module ifm_buffer_top (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic                         rd_clr_1,
    input  logic                         wr_clr_1,
    input  ifm_buffer_pkg::lane_mask_t   rd_en_1,
    input  logic                         wr_en_1,

    input  logic                         rd_clr_2,
    input  logic                         wr_clr_2,
    input  ifm_buffer_pkg::lane_mask_t   rd_en_2,
    input  logic                         wr_en_2,

    input  logic                         ifm_demux,  // write bank
    input  logic                         ifm_mux,    // read bank
    input  ifm_buffer_pkg::tile_idx_t    count_tiling,
    input  ifm_buffer_pkg::map_size_t    count_tiling_mod_ofm_size,

    input  ifm_buffer_pkg::lane_cnt_t    read_ifm_size,
    input  logic                         ofm_read_en,

    input  ifm_buffer_pkg::lane_bus_t    data_in,
    output ifm_buffer_pkg::lane_bus_t    data_out,

    input  logic [`IFM_LAYER_WIDTH-1:0]  count_layer,
    input  logic [`IFM_KERNEL_WIDTH-1:0] kernel_size,
    input  ifm_buffer_pkg::map_size_t    ofm_size,
    input  ifm_buffer_pkg::tile_idx_t    num_tiling
);

    ifm_buffer_pkg::lane_bus_t data_pad;

    pad_ctrl_if  pad_if ();
    bank_ctrl_if bank_if ();

    // shared strobes for all lanes
    assign bank_if.rd_clr_1 = rd_clr_1;
    assign bank_if.wr_clr_1 = wr_clr_1;
    assign bank_if.wr_en_1  = wr_en_1;
    assign bank_if.rd_clr_2 = rd_clr_2;
    assign bank_if.wr_clr_2 = wr_clr_2;
    assign bank_if.wr_en_2  = wr_en_2;
    assign bank_if.wr_bank  = ifm_demux;
    assign bank_if.rd_bank  = ifm_mux;

    ifm_pad_ctrl ifm_pad_ctrl_i (
        .clk                       (clk),
        .rst_n                     (rst_n),
        .ofm_read_en               (ofm_read_en),
        .kernel_size               (kernel_size),
        .count_layer               (count_layer),
        .count_tiling              (count_tiling),
        .count_tiling_mod_ofm_size (count_tiling_mod_ofm_size),
        .ofm_size                  (ofm_size),
        .num_tiling                (num_tiling),
        .read_ifm_size             (read_ifm_size),
        .ctl                       (pad_if.ctrl)
    );

    ifm_pad_datapath ifm_pad_datapath_i (
        .data_in  (data_in),
        .ctl      (pad_if.dp),
        .data_pad (data_pad)
    );

    for (genvar k = 0; k < `IFM_NUM_LANES; k++) begin : g_lane
        ifm_lane_fifo ifm_lane_fifo_i (
            .clk      (clk),
            .rst_n    (rst_n),
            .bank     (bank_if.lane),
            .rd_en_1  (rd_en_1[k]),
            .rd_en_2  (rd_en_2[k]),
            .data_in  (data_pad[k]),
            .data_out (data_out[k])
        );
    end

endmodule

// File: hdl/ifm_lane_fifo.sv
/* two-bank FIFO for one lane with one cycle read latency
   no full or empty flags, pointers wrap at the depth, clears win over enables */
`timescale 1ns/100ps
`include "ifm_buffer_settings.svh"

module ifm_lane_fifo (
    input  logic                       clk,
    input  logic                       rst_n,
    bank_ctrl_if.lane                  bank,
    input  logic                       rd_en_1,
    input  logic                       rd_en_2,
    input  logic [`IFM_DATA_WIDTH-1:0] data_in,
    output logic [`IFM_DATA_WIDTH-1:0] data_out
);

    localparam int ADDR_W = $clog2(`IFM_FIFO_DEPTH);

    logic [1:0]                 wr_en;
    logic [1:0]                 wr_clr;
    logic [1:0]                 rd_en;
    logic [1:0]                 rd_clr;
    logic [`IFM_DATA_WIDTH-1:0] rd_data [2];

    // index 0 is bank 1, index 1 is bank 2
    assign wr_en  = {bank.wr_en_2 & bank.wr_bank, bank.wr_en_1 & ~bank.wr_bank};
    assign wr_clr = {bank.wr_clr_2, bank.wr_clr_1};
    assign rd_en  = {rd_en_2, rd_en_1};
    assign rd_clr = {bank.rd_clr_2, bank.rd_clr_1};

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [`IFM_DATA_WIDTH-1:0] mem [`IFM_FIFO_DEPTH];
        logic [ADDR_W-1:0]          wr_ptr;
        logic [ADDR_W-1:0]          rd_ptr;

        always_ff @(posedge clk) begin
            if (wr_en[b] && !wr_clr[b]) begin
                mem[wr_ptr] <= data_in;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                wr_ptr <= '0;
            end else if (wr_clr[b]) begin
                wr_ptr <= '0;
            end else if (wr_en[b]) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rd_ptr     <= '0;
                rd_data[b] <= '0;
            end else if (rd_clr[b]) begin
                rd_ptr <= '0;  // output register keeps the last word
            end else if (rd_en[b]) begin
                rd_ptr     <= rd_ptr + 1'b1;
                rd_data[b] <= mem[rd_ptr];
            end
        end
    end

    assign data_out = rd_data[bank.rd_bank];

endmodule

// File: hdl/ifm_pad_ctrl.sv
/* window phase counter and tile border decode
   bottom edge decode expects num_tiling >= ofm_size */
`timescale 1ns/100ps
`include "ifm_buffer_settings.svh"

module ifm_pad_ctrl (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic                             ofm_read_en,
    input  logic [`IFM_KERNEL_WIDTH-1:0]     kernel_size,
    input  logic [`IFM_LAYER_WIDTH-1:0]      count_layer,
    input  ifm_buffer_pkg::tile_idx_t        count_tiling,
    input  ifm_buffer_pkg::map_size_t        count_tiling_mod_ofm_size,
    input  ifm_buffer_pkg::map_size_t        ofm_size,
    input  ifm_buffer_pkg::tile_idx_t        num_tiling,
    input  ifm_buffer_pkg::lane_cnt_t        read_ifm_size,
    pad_ctrl_if.ctrl                         ctl
);

    ifm_buffer_pkg::phase_t    phase_q;
    ifm_buffer_pkg::tile_idx_t ofm_size_ext;
    ifm_buffer_pkg::pad_mode_e pad_mode;
    logic                      pad_active;
    logic                      edge_top;
    logic                      edge_bottom;
    logic                      edge_left;
    logic                      edge_right;
    logic [1:0]                win_row;
    logic [1:0]                win_col;

    // 0 whenever ofm_read_en drops, 0..8 while it stays high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase_q <= '0;
        end else if (ofm_read_en) begin
            phase_q <= (phase_q == `IFM_PHASE_LAST) ? '0 : phase_q + 1'b1;
        end else begin
            phase_q <= '0;
        end
    end

    assign pad_active = (kernel_size == `IFM_PAD_KERNEL) &&
                        (count_layer >= `IFM_PAD_FIRST_LAYER);

    assign ofm_size_ext = ifm_buffer_pkg::tile_idx_t'(ofm_size);

    // tiles of the output map count from 1
    assign edge_top    = count_tiling <= ofm_size_ext;
    assign edge_bottom = count_tiling > (num_tiling - ofm_size_ext);
    assign edge_left   = count_tiling_mod_ofm_size == ifm_buffer_pkg::map_size_t'(1);
    assign edge_right  = count_tiling_mod_ofm_size == '0;

    assign win_row = 2'(phase_q / 4'd3);
    assign win_col = 2'(phase_q % 4'd3);

    always_comb begin
        pad_mode = ifm_buffer_pkg::PAD_PASS;
        if (pad_active) begin
            if ((edge_top && win_row == 2'd0) || (edge_bottom && win_row == 2'd2)) begin
                pad_mode = ifm_buffer_pkg::PAD_ZERO;
            end else if (edge_left && win_col == 2'd0) begin
                pad_mode = ifm_buffer_pkg::PAD_SHIFT;
            end else if (edge_right && win_col == 2'd2) begin
                pad_mode = ifm_buffer_pkg::PAD_TRIM;
            end
        end
    end

    assign ctl.lane_count = read_ifm_size;
    assign ctl.pad_mode   = pad_mode;
    assign ctl.phase      = phase_q;
    assign ctl.pad_active = pad_active;

endmodule

// File: hdl/ifm_pad_datapath.sv
/* combinational lane mask and border padding with zero latency
   phase and pad_active arrive on ctl for waves only */
`timescale 1ns/100ps
`include "ifm_buffer_settings.svh"

module ifm_pad_datapath (
    input  ifm_buffer_pkg::lane_bus_t data_in,
    pad_ctrl_if.dp                    ctl,
    output ifm_buffer_pkg::lane_bus_t data_pad
);

    ifm_buffer_pkg::lane_bus_t masked;
    ifm_buffer_pkg::lane_bus_t trimmed;
    ifm_buffer_pkg::lane_bus_t shifted;

    // lanes at or above lane_count carry zero
    always_comb begin
        for (int k = 0; k < `IFM_NUM_LANES; k++) begin
            if (k < int'(ctl.lane_count)) begin
                masked[k] = data_in[k];
            end else begin
                masked[k] = '0;
            end
        end
    end

    // masked bus without its last valid lane
    always_comb begin
        for (int k = 0; k < `IFM_NUM_LANES; k++) begin
            if (k + 1 < int'(ctl.lane_count)) begin
                trimmed[k] = data_in[k];
            end else begin
                trimmed[k] = '0;
            end
        end
    end

    // one lane up so lane 0 becomes the left pad
    assign shifted = masked << `IFM_DATA_WIDTH;

    always_comb begin
        case (ctl.pad_mode)
            ifm_buffer_pkg::PAD_ZERO:  data_pad = '0;
            ifm_buffer_pkg::PAD_SHIFT: data_pad = shifted;
            ifm_buffer_pkg::PAD_TRIM:  data_pad = trimmed;
            default:                   data_pad = masked;
        endcase
    end

endmodule

// File: tests/tb_ifm_buffer_model.svh
/* reference model of the ifm buffer to be included in tb_ifm_buffer after its signals
   assumes reads never run past the written words and wr_clr comes with rd_clr */
`ifndef TB_IFM_BUFFER_MODEL_SVH
`define TB_IFM_BUFFER_MODEL_SVH

bit [31:0]                  lfsr_state  = 32'hb4145a62;
int                         model_phase = 0;
ifm_buffer_pkg::lane_word_t lane_q  [2][`IFM_NUM_LANES][$];  // words not read yet
ifm_buffer_pkg::lane_word_t saved_q [2][`IFM_NUM_LANES][$];  // all words since wr_clr
ifm_buffer_pkg::lane_bus_t  out_reg [2] = '{default: '0};

function automatic bit lfsr_step();
    bit fb;
    fb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (fb) begin
        lfsr_state = lfsr_state ^ 32'h80200003;  // taps 32 22 2 1
    end
    return fb;
endfunction

function automatic bit [31:0] rand_bits(int n);
    bit [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsr_step()};
    end
    return v;
endfunction

// padded word for the inputs on the bus and the model's window phase
function automatic ifm_buffer_pkg::lane_bus_t expected_pad();
    ifm_buffer_pkg::lane_bus_t w;
    int                        lanes;
    int                        row;
    int                        col;
    bit                        active;
    bit                        top;
    bit                        bottom;
    w      = '0;
    lanes  = int'(read_ifm_size);
    row    = model_phase / 3;
    col    = model_phase % 3;
    active = (kernel_size == 2'd3) && (count_layer >= 4'd2);
    top    = int'(count_tiling) <= int'(ofm_size);
    bottom = int'(count_tiling) > int'(num_tiling) - int'(ofm_size);
    for (int k = 0; k < lanes; k++) begin
        w[k] = data_in[k];
    end
    if (!active) begin
        return w;
    end
    if ((top && row == 0) || (bottom && row == 2)) begin
        return '0;
    end
    if (count_tiling_mod_ofm_size == 9'd1 && col == 0) begin
        w = {w[`IFM_NUM_LANES-2:0], 16'h0000};  // left pad in lane 0
    end else if (count_tiling_mod_ofm_size == 9'd0 && col == 2 && lanes > 0) begin
        w[lanes - 1] = '0;
    end
    return w;
endfunction

// one rising edge of the buffer with bank 1 at index 0
task automatic model_clock();
    ifm_buffer_pkg::lane_bus_t w;
    bit [1:0]                  wen;
    bit [1:0]                  wclr;
    bit [1:0]                  rclr;
    bit [1:0]                  ren;
    w    = expected_pad();
    wen  = {wr_en_2 && ifm_demux, wr_en_1 && !ifm_demux};
    wclr = {wr_clr_2, wr_clr_1};
    rclr = {rd_clr_2, rd_clr_1};
    for (int b = 0; b < 2; b++) begin
        for (int k = 0; k < `IFM_NUM_LANES; k++) begin
            ren = {rd_en_2[k], rd_en_1[k]};
            if (!rclr[b] && ren[b]) begin
                out_reg[b][k] = lane_q[b][k].pop_front();
            end
            if (wclr[b]) begin
                lane_q[b][k].delete();
                saved_q[b][k].delete();
            end else if (wen[b]) begin
                lane_q[b][k].push_back(w[k]);
                saved_q[b][k].push_back(w[k]);
            end
            if (rclr[b]) begin
                lane_q[b][k] = saved_q[b][k];  // replay from the first word
            end
        end
    end
    model_phase = (!ofm_read_en || model_phase == 8) ? 0 : model_phase + 1;
endtask

`endif

// File: tests/tb_ifm_buffer.sv
/* random stimulus for ifm_buffer_top checked against the included model
   inputs change on the falling edge, data_out is compared on every falling edge */
`timescale 1ns/100ps
`include "ifm_buffer_settings.svh"

module tb_ifm_buffer;

    localparam int N_PASS = 40;
    localparam int N_WIN  = 7;   // padded windows of 9 phases
    localparam int N_DBL  = 16;
    localparam int N_LANE = 12;
    localparam int N_RAND = 30;
    localparam int MAP    = 4;   // output map is MAP x MAP tiles
    localparam int PLANNED_CYCLES = 12 + 2 * N_PASS + 18 * N_WIN + 4 * N_DBL
                                    + 2 * N_LANE + N_RAND + 50;

    logic                       clk;
    logic                       rst_n;
    logic                       rd_clr_1;
    logic                       wr_clr_1;
    logic                       wr_en_1;
    logic                       rd_clr_2;
    logic                       wr_clr_2;
    logic                       wr_en_2;
    ifm_buffer_pkg::lane_mask_t rd_en_1;
    ifm_buffer_pkg::lane_mask_t rd_en_2;
    logic                       ifm_demux;
    logic                       ifm_mux;
    ifm_buffer_pkg::tile_idx_t  count_tiling;
    ifm_buffer_pkg::map_size_t  count_tiling_mod_ofm_size;
    ifm_buffer_pkg::lane_cnt_t  read_ifm_size;
    logic                       ofm_read_en;
    ifm_buffer_pkg::lane_bus_t  data_in;
    ifm_buffer_pkg::lane_bus_t  data_out;
    logic [3:0]                 count_layer;
    logic [1:0]                 kernel_size;
    ifm_buffer_pkg::map_size_t  ofm_size;
    ifm_buffer_pkg::tile_idx_t  num_tiling;

    int cycle_cnt = 0;
    int err_cnt   = 0;
    int check_cnt = 0;
    int test_cnt  = 0;
    int test_err0 = 0;

    // tile band of each window (0 first row or column, 1 inner, 2 last)
    int row_sel [N_WIN] = '{0, 1, 2, 1, 1, 0, 2};
    int col_sel [N_WIN] = '{0, 1, 2, 0, 2, 1, 1};

    `include "tb_ifm_buffer_model.svh"

    ifm_buffer_top ifm_buffer_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 2 * PLANNED_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    task automatic check_bus(input ifm_buffer_pkg::lane_bus_t actual,
                             input ifm_buffer_pkg::lane_bus_t expected, input string what);
        check_cnt++;
        for (int k = 0; k < `IFM_NUM_LANES; k++) begin
            if (actual[k] !== expected[k]) begin
                $display("Error at %0t: %s lane %0d got %h expected %h",
                         $time, what, k, actual[k], expected[k]);
                err_cnt++;
            end
        end
    endtask

    // model follows the edge and the output is checked half a cycle later
    task automatic tick();
        @(posedge clk);
        model_clock();
        @(negedge clk);
        check_bus(data_out, out_reg[ifm_mux], "data_out");
    endtask

    task automatic idle();
        wr_en_1     = 1'b0;
        wr_en_2     = 1'b0;
        rd_en_1     = '0;
        rd_en_2     = '0;
        rd_clr_1    = 1'b0;
        wr_clr_1    = 1'b0;
        rd_clr_2    = 1'b0;
        wr_clr_2    = 1'b0;
        ofm_read_en = 1'b0;
    endtask

    task automatic new_word();
        for (int k = 0; k < `IFM_NUM_LANES; k++) begin
            data_in[k] = ifm_buffer_pkg::lane_word_t'(rand_bits(16));
        end
        read_ifm_size = ifm_buffer_pkg::lane_cnt_t'(rand_bits(5) % 17);
    endtask

    task automatic clear_banks(bit b1, bit b2);
        rd_clr_1 = b1;
        wr_clr_1 = b1;
        rd_clr_2 = b2;
        wr_clr_2 = b2;
        tick();
        idle();
    endtask

    task automatic report_test(string name);
        test_cnt++;
        $display("test %0d %s: done, %0d errors", test_cnt, name, err_cnt - test_err0);
        test_err0 = err_cnt;
    endtask

    function automatic int band_pos(int sel);
        int pos;
        pos = MAP - 1;
        if (sel == 0) begin
            pos = 0;
        end else if (sel == 1) begin
            pos = 1 + int'(rand_bits(1));
        end
        return pos;
    endfunction

    initial begin
        int row;
        int col;
        idle();
        rst_n                     = 1'b0;
        data_in                   = '0;
        read_ifm_size             = 5'd16;
        ifm_demux                 = 1'b0;
        ifm_mux                   = 1'b0;
        count_tiling              = 14'd1;
        count_tiling_mod_ofm_size = 9'd1;
        ofm_size                  = 9'(MAP);
        num_tiling                = 14'(MAP * MAP);
        count_layer               = 4'd0;
        kernel_size               = 2'd0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        repeat (3) tick();
        report_test("reset state");

        // padding stays off with a 1x1 kernel or layer 1
        for (int i = 0; i < N_PASS; i++) begin
            new_word();
            kernel_size = (i < N_PASS / 2) ? 2'd1 : 2'd3;
            count_layer = (i < N_PASS / 2) ? 4'(rand_bits(4)) : 4'd1;
            ofm_read_en = 1'b1;
            wr_en_1     = 1'b1;
            tick();
        end
        idle();
        rd_en_1 = '1;
        repeat (N_PASS) tick();
        idle();
        clear_banks(1'b1, 1'b0);
        report_test("pass-through with lane mask");

        kernel_size = 2'd3;
        count_layer = 4'(2 + rand_bits(3));
        for (int w = 0; w < N_WIN; w++) begin
            row = band_pos(row_sel[w]);
            col = band_pos(col_sel[w]);
            count_tiling = ifm_buffer_pkg::tile_idx_t'(row * MAP + col + 1);
            count_tiling_mod_ofm_size = ifm_buffer_pkg::map_size_t'((row * MAP + col + 1) % MAP);
            for (int p = 0; p < 9; p++) begin
                new_word();
                wr_en_1     = 1'b1;
                ofm_read_en = 1'b1;
                tick();
            end
        end
        idle();
        rd_en_1 = '1;
        repeat (9 * N_WIN) tick();
        idle();
        clear_banks(1'b1, 1'b0);
        report_test("border padding");

        kernel_size = 2'd1;
        for (int i = 0; i < N_DBL; i++) begin
            new_word();
            wr_en_1 = 1'b1;
            tick();
        end
        for (int i = 0; i < N_DBL; i++) begin
            new_word();
            wr_en_1   = 1'b1;  // ignored while bank 2 is selected
            wr_en_2   = 1'b1;
            ifm_demux = 1'b1;
            rd_en_1   = '1;
            tick();
        end
        idle();
        ifm_mux = 1'b1;
        tick();
        ifm_mux = 1'b0;
        tick();
        ifm_mux = 1'b1;
        clear_banks(1'b1, 1'b0);
        for (int i = 0; i < N_DBL; i++) begin
            new_word();
            wr_en_1   = 1'b1;
            wr_en_2   = 1'b1;
            ifm_demux = 1'b0;
            rd_en_2   = '1;
            tick();
        end
        idle();
        ifm_mux = 1'b0;
        rd_en_1 = '1;
        repeat (N_DBL) tick();
        idle();
        clear_banks(1'b1, 1'b1);
        report_test("double buffering");

        ifm_demux = 1'b1;
        ifm_mux   = 1'b1;
        for (int i = 0; i < N_LANE; i++) begin
            new_word();
            wr_en_2 = 1'b1;
            tick();
        end
        idle();
        for (int i = 0; i < N_RAND; i++) begin
            for (int k = 0; k < `IFM_NUM_LANES; k++) begin
                rd_en_2[k] = (rand_bits(1) != 0) && (lane_q[1][k].size() > 0);
            end
            tick();
        end
        repeat (N_LANE) begin
            for (int k = 0; k < `IFM_NUM_LANES; k++) begin
                rd_en_2[k] = lane_q[1][k].size() > 0;  // drain what is left
            end
            tick();
        end
        idle();
        clear_banks(1'b0, 1'b1);
        report_test("per-lane reads");

        ifm_demux = 1'b0;
        ifm_mux   = 1'b0;
        for (int i = 0; i < 10; i++) begin
            new_word();
            wr_en_1 = 1'b1;
            tick();
        end
        idle();
        rd_en_1 = '1;
        repeat (5) tick();
        idle();
        rd_clr_1 = 1'b1;
        tick();
        idle();
        rd_en_1 = '1;
        repeat (10) tick();
        idle();
        clear_banks(1'b1, 1'b0);
        for (int i = 0; i < 6; i++) begin
            new_word();
            wr_en_1 = 1'b1;
            tick();
        end
        idle();
        rd_en_1 = '1;
        repeat (6) tick();
        idle();
        tick();
        report_test("clears");

        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
